// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decode unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=decode_unit_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
    --top-module decode_unit_tb \
    -f verilog.f \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"

if grep -q "TEST FAIL" "$LOG_FILE"; then
    echo "Simulation reported a failure, see $LOG_FILE"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if ! grep -q "TEST PASS" "$LOG_FILE"; then
    echo "Simulation ended without a result line"
    exit 1
fi

echo "Simulation passed"
exit 0

// ==== tests/decode_unit_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_unit_checker
    import decode_pkg::*;
(
    input wire sim_clk,
    input wire rst_n,
    input wire rep_valid,
    input wire rep_ready,
    input wire decode_report_t rep
);

    logic read_only_hit;
    logic write_only_hit;

    assign read_only_hit = rep.strobes.crca || rep.strobes.disa || rep.strobes.diad
                        || rep.strobes.tsa || rep.strobes.ssa || rep.strobes.dara;
    assign write_only_hit = rep.strobes.lga || rep.strobes.dos || rep.strobes.ssr
                         || rep.strobes.dor || rep.strobes.icr;

    //////////////////////////////////////////////////
    // Report channel
    //////////////////////////////////////////////////

    // A stalled report stays valid and unchanged.
    rep_hold_a: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
        rep_valid && !rep_ready |=> rep_valid && $stable(rep)
    ) else $error("report changed or vanished while stalled");

    rep_reset_a: assert property (
        @(posedge sim_clk) !rst_n |=> !rep_valid
    ) else $error("rep_valid high right after reset");

    //////////////////////////////////////////////////
    // Strobe groups
    //////////////////////////////////////////////////

    write_group_a: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
        rep_valid && rep.cmd.kind == CMD_WRITE |-> !read_only_hit
    ) else $error("read-only strobe set in a write report");

    read_group_a: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
        rep_valid && rep.cmd.kind == CMD_READ |-> !write_only_hit
    ) else $error("write-only strobe set in a read report");

endmodule : decode_unit_checker

`default_nettype wire

// ==== tests/decode_unit_tb.sv ====
`timescale 1ns/1ns
`include "adc_defines.svh"
`default_nettype none

module decode_unit_tb
    import decode_pkg::*;
;

    logic           sim_clk = 1'b0;
    logic           rst_n;
    logic           cmd_valid;
    logic           cmd_ready;
    decode_cmd_t    cmd;
    logic           rep_valid;
    logic           rep_ready = 1'b0;
    decode_report_t rep;

    decode_cmd_t    cmd_table[$];
    strobes_t       exp_table[$];
    int             rep_count = 0;
    logic           stalled = 1'b0;
    decode_report_t stalled_rep;
    logic [31:0]    lcg_state = 32'd88;

    always #4 sim_clk = ~sim_clk; // 8 ns period.

    decode_unit decode_unit_i (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .rep_valid (rep_valid),
        .rep_ready (rep_ready),
        .rep       (rep)
    );

    bind decode_unit decode_unit_checker checker_i (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .rep_valid (rep_valid),
        .rep_ready (rep_ready),
        .rep       (rep)
    );

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_cmd(input decode_cmd_t actual, input decode_cmd_t expected,
                             input string what);
        if (actual !== expected) begin
            fail_run($sformatf("Fail at %0t ns: %s command %b, expected %b",
                               $time, what, actual, expected));
        end
    endtask

    // Bit order lga, crca, disa, diad, tsa, ssa, dos, ssr, dor, icr, dara.
    task automatic check_strobes(input strobes_t actual, input strobes_t expected,
                                 input string what);
        if (actual !== expected) begin
            fail_run($sformatf("Fail at %0t ns: %s strobes %b, expected %b",
                               $time, what, actual, expected));
        end
    endtask

    task automatic add_entry(input cmd_kind_e kind, input addr_t addr,
                             input strobes_t strobes);
        decode_cmd_t c;
        c.kind = kind;
        c.addr = addr;
        cmd_table.push_back(c);
        exp_table.push_back(strobes);
    endtask

    // Addresses run A7 down to A1. Strobes group as lga, reads, writes and dara.
    task automatic fill_table();
        add_entry(CMD_WRITE, 7'b1000000, 11'b1_00000_0000_0); // lga.
        add_entry(CMD_READ,  7'b0100000, 11'b0_10000_0000_0); // crca.
        add_entry(CMD_READ,  7'b0101000, 11'b0_01000_0000_0); // disa.
        add_entry(CMD_READ,  7'b0101110, 11'b0_00100_0000_1); // diad and dara.
        add_entry(CMD_READ,  7'b0110100, 11'b0_00010_0000_0); // tsa.
        add_entry(CMD_READ,  7'b0111101, 11'b0_00001_0000_0); // ssa with A1 high.
        add_entry(CMD_WRITE, 7'b0001100, 11'b0_00000_1010_0); // dos with dor.
        add_entry(CMD_WRITE, 7'b0011100, 11'b0_00000_0100_0); // ssr.
        add_entry(CMD_WRITE, 7'b0001000, 11'b0_00000_0010_0); // dor alone.
        add_entry(CMD_WRITE, 7'b0010000, 11'b0_00000_0001_0); // icr.
        add_entry(CMD_WRITE, 7'b0010100, 11'b0_00000_0001_0); // icr with A3 high.
        add_entry(CMD_READ,  7'b0000010, 11'b0_00000_0000_1); // dara.
        add_entry(CMD_READ,  7'b0001100, 11'b0_00000_0000_0); // dos address as a read.
        add_entry(CMD_WRITE, 7'b0100000, 11'b0_00000_0000_0); // crca address as a write.
        add_entry(CMD_WRITE, 7'b1011110, 11'b1_00000_0000_0);
        add_entry(CMD_READ,  7'b1111111, 11'b0_00000_0000_0); // Nothing.
    endtask

    task automatic send_cmd(input decode_cmd_t c);
        @(posedge sim_clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(negedge sim_clk);
        while (!cmd_ready) begin
            @(negedge sim_clk);
        end
        @(posedge sim_clk); // Transfer edge.
        cmd_valid <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Report side
    //////////////////////////////////////////////////

    always @(posedge sim_clk) begin
        if (!rst_n) begin
            rep_ready <= 1'b0;
        end else begin
            lcg_state = lcg_next(lcg_state);
            rep_ready <= (lcg_state[17:16] != 2'b00); // Low about a quarter of cycles.
        end
    end

    always @(negedge sim_clk) begin
        if (rst_n) begin
            if (stalled) begin
                if (!rep_valid) begin
                    fail_run("rep_valid dropped before the report was taken");
                end else begin
                    check_cmd(rep.cmd, stalled_rep.cmd, "held report");
                    check_strobes(rep.strobes, stalled_rep.strobes, "held report");
                end
            end
            if (rep_valid && rep_ready) begin
                if (rep_count >= cmd_table.size()) begin
                    fail_run("a report arrived with no command left to match it");
                end else begin
                    check_cmd(rep.cmd, cmd_table[rep_count], "echoed");
                    check_strobes(rep.strobes, exp_table[rep_count], "reported");
                    rep_count++;
                end
            end
            stalled     = rep_valid && !rep_ready;
            stalled_rep = rep;
        end
    end

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        fill_table();
        repeat (10) @(posedge sim_clk);
        rst_n <= 1'b1;
        for (int i = 0; i < cmd_table.size(); i++) begin
            send_cmd(cmd_table[i]);
        end
        wait (rep_count == cmd_table.size());
        repeat (2 * `ADC_WORD_SLOTS) @(negedge sim_clk);
        if (rep_valid) begin
            fail_run("an extra report appeared after the last command");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

    initial begin
        int timeout_cycles;
        #1;
        timeout_cycles = (cmd_table.size() + 4) * `ADC_WORD_SLOTS * 4;
        repeat (timeout_cycles) @(posedge sim_clk);
        $display("The run timed out before all reports came back");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule : decode_unit_tb

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/timing_pkg.sv
verilog/decode_pkg.sv
verilog/hold_stage.sv
verilog/phase_timer.sv
verilog/address_decode.sv
verilog/decode_unit.sv
tests/decode_unit_checker.sv
tests/decode_unit_tb.sv

// ==== verilog/adc_defines.svh ====
`default_nettype none
`ifndef ADC_DEFINES_SVH
`define ADC_DEFINES_SVH

//////////////////////////////////////////////////
// Word timing
//////////////////////////////////////////////////

`define ADC_WORD_SLOTS 8 // Slots in one word.

// Slot positions inside a word.
`define ADC_SLOT_LOAD   3'd0 // Command loaded, input popped.
`define ADC_SLOT_CLEAR  3'd1 // Parity-sync clear of all latches.
`define ADC_SLOT_WRITE  3'd5 // Write commands set (W8).
`define ADC_SLOT_READ   3'd6 // Read commands set (Y8).
`define ADC_SLOT_REPORT 3'd7 // Report offered downstream.

`endif
`default_nettype wire

// ==== verilog/address_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module address_decode
    import timing_pkg::*;
    import decode_pkg::*;
(
    input  wire            sim_clk,
    input  wire            rst_n,

    input  wire            timing_phases_t phases,
    input  wire            decode_cmd_t cmd,

    output decode_report_t rep
);

    decode_cmd_t cmd_q;
    strobes_t    latch_q;
    strobes_t    write_hits;
    strobes_t    read_hits;
    logic [4:0]  a73;      // A7..A3.
    logic        write_en;
    logic        read_en;

    //////////////////////////////////////////////////
    // Address register
    //////////////////////////////////////////////////

    always_ff @(posedge sim_clk) begin
        if (phases.load) begin
            cmd_q <= cmd;
        end
    end

    assign a73 = cmd_q.addr[6:2];

    //////////////////////////////////////////////////
    // Match rules
    //////////////////////////////////////////////////

    // Write group, gated by W8.
    always_comb begin
        write_hits      = '0;
        write_hits.lga  = cmd_q.addr[6];
        write_hits.dos  = (a73 == 5'b00011);
        write_hits.ssr  = (a73 == 5'b00111);
        write_hits.dor  = (a73[4:1] == 4'b0001); // A3 ignored.
        write_hits.icr  = (a73[4:1] == 4'b0010);
    end

    // Read group, gated by Y8.
    always_comb begin
        read_hits       = '0;
        read_hits.crca  = (a73 == 5'b01000);
        read_hits.disa  = (a73 == 5'b01010);
        read_hits.diad  = (a73 == 5'b01011);
        read_hits.tsa   = (a73 == 5'b01101);
        read_hits.ssa   = (a73 == 5'b01111);
        read_hits.dara  = !cmd_q.addr[0] && cmd_q.addr[1]; // A1 low, A2 high.
    end

    assign write_en = phases.write_set && (cmd_q.kind == CMD_WRITE);
    assign read_en  = phases.read_set && (cmd_q.kind == CMD_READ);

    //////////////////////////////////////////////////
    // Strobe latches
    //////////////////////////////////////////////////

    // Set holds until the next parity-sync clear.
    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            latch_q <= '0;
        end else if (phases.clear) begin
            latch_q <= '0;
        end else if (write_en) begin
            latch_q <= latch_q | write_hits;
        end else if (read_en) begin
            latch_q <= latch_q | read_hits;
        end
    end

    assign rep.cmd     = cmd_q;
    assign rep.strobes = latch_q;

endmodule : address_decode

`default_nettype wire

// ==== verilog/decode_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////
// Address decode types
//////////////////////////////////////////////////

package decode_pkg;

    // Device address, index 0 is A1, index 6 is A7.
    typedef logic [6:0] addr_t;

    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } cmd_kind_e;

    // Command as it arrives on the input channel.
    typedef struct packed {
        cmd_kind_e kind;
        addr_t     addr;
    } decode_cmd_t;

    // One bit per strobe latch.
    typedef struct packed {
        logic lga;  // Write, A7.
        logic crca; // Read strobes start here.
        logic disa;
        logic diad;
        logic tsa;
        logic ssa;
        logic dos;  // Write strobes again.
        logic ssr;
        logic dor;
        logic icr;
        logic dara; // Read, A1/A2 only.
    } strobes_t;

    // Echoed command plus the latched strobes of its word.
    typedef struct packed {
        decode_cmd_t cmd;
        strobes_t    strobes;
    } decode_report_t;

endpackage : decode_pkg

`default_nettype wire

// ==== verilog/decode_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_unit
    import timing_pkg::*;
    import decode_pkg::*;
(
    input  wire            sim_clk,
    input  wire            rst_n,

    // Command channel.
    input  wire            cmd_valid,
    output logic           cmd_ready,
    input  wire            decode_cmd_t cmd,

    // Report channel.
    output logic           rep_valid,
    input  wire            rep_ready,
    output decode_report_t rep
);

    logic           held_valid;
    decode_cmd_t    held_cmd;
    timing_phases_t phases;
    decode_report_t word_rep;
    logic           rep_space;

    //////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////

    hold_stage #(
        .payload_t (decode_cmd_t)
    ) cmd_stage_i (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .in_valid  (cmd_valid),
        .in_ready  (cmd_ready),
        .in_data   (cmd),
        .out_valid (held_valid),
        .out_ready (phases.load), // Popped in the load slot.
        .out_data  (held_cmd)
    );

    //////////////////////////////////////////////////
    // Word timing and decode
    //////////////////////////////////////////////////

    phase_timer phase_timer_i (
        .sim_clk      (sim_clk),
        .rst_n        (rst_n),
        .cmd_present  (held_valid),
        .report_space (rep_space),
        .phases       (phases)
    );

    address_decode address_decode_i (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .phases  (phases),
        .cmd     (held_cmd),
        .rep     (word_rep)
    );

    //////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////

    // Only back-pressure path, stalls the whole word.
    hold_stage #(
        .payload_t (decode_report_t)
    ) rep_stage_i (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .in_valid  (phases.report),
        .in_ready  (rep_space),
        .in_data   (word_rep),
        .out_valid (rep_valid),
        .out_ready (rep_ready),
        .out_data  (rep)
    );

endmodule : decode_unit

`default_nettype wire

// ==== verilog/hold_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

// Single entry register slice with a full flag.
module hold_stage #(
    parameter type payload_t = logic
) (
    input  wire      sim_clk,
    input  wire      rst_n,

    input  wire      in_valid,
    output logic     in_ready,
    input  wire      payload_t in_data,

    output logic     out_valid,
    input  wire      out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;
    logic     push;

    // Empty, or drained in this same cycle.
    assign in_ready = !full || out_ready;
    assign push     = in_valid && in_ready;

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (push) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0; // Popped, nothing new.
        end
    end

    always_ff @(posedge sim_clk) begin
        if (push) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data  = data_q;

endmodule : hold_stage

`default_nettype wire

// ==== verilog/phase_timer.sv ====
`timescale 1ns/1ns
`include "adc_defines.svh"
`default_nettype none

module phase_timer
    import timing_pkg::*;
(
    input  wire            sim_clk,
    input  wire            rst_n,

    input  wire            cmd_present,  // Input stage holds a command.
    input  wire            report_space, // Output stage can take a report.

    output timing_phases_t phases
);

    slot_t slot;
    slot_t slot_next;
    logic  word_end;
    logic  hold;

    //////////////////////////////////////////////////
    // Slot counter
    //////////////////////////////////////////////////

    assign word_end = (slot == slot_t'(`ADC_WORD_SLOTS - 1));

    // Wait for a command in the load slot, and for space in the report slot.
    always_comb begin
        hold = 1'b0;
        if (slot == `ADC_SLOT_LOAD && !cmd_present) begin
            hold = 1'b1;
        end
        if (slot == `ADC_SLOT_REPORT && !report_space) begin
            hold = 1'b1;
        end
    end

    always_comb begin
        if (hold) begin
            slot_next = slot;
        end else if (word_end) begin
            slot_next = '0;
        end else begin
            slot_next = slot + slot_t'(1);
        end
    end

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            slot <= '0;
        end else begin
            slot <= slot_next;
        end
    end

    //////////////////////////////////////////////////
    // Phase decode
    //////////////////////////////////////////////////

    always_comb begin
        phases.load      = (slot == `ADC_SLOT_LOAD) && cmd_present;
        phases.clear     = (slot == `ADC_SLOT_CLEAR);
        phases.write_set = (slot == `ADC_SLOT_WRITE);
        phases.read_set  = (slot == `ADC_SLOT_READ);
        phases.report    = (slot == `ADC_SLOT_REPORT); // Stays up while stalled.
    end

endmodule : phase_timer

`default_nettype wire

// ==== verilog/timing_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////
// Word timing types
//////////////////////////////////////////////////

package timing_pkg;

    // Slot number within a word.
    typedef logic [2:0] slot_t;

    // One-cycle phase pulses decoded from the slot counter.
    typedef struct packed {
        logic load;      // Load command, pop input.
        logic clear;     // Clear every strobe latch.
        logic write_set; // Write slot.
        logic read_set;  // Read slot.
        logic report;    // Push report, held under back-pressure.
    } timing_phases_t;

endpackage : timing_pkg

`default_nettype wire
